/* src/n64_vbus_pkg.sv */
package n64_vbus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // multiplexed N64 video bus

  localparam int color_w = 7;                  // one color component on VD_i
  localparam int sync_w  = 4;                  // sync nibble width
  localparam int vdata_w = 3*color_w + sync_w; // packed pixel {sync, R, G, B}

  // field offsets inside a packed pixel
  localparam int sync_lsb = 3*color_w;
  localparam int r_lsb    = 2*color_w;
  localparam int g_lsb    = color_w;
  localparam int b_lsb    = 0;

  // sync bits inside the nibble, all active low on the bus
  localparam int vsync_b = 3;  // nVSYNC
  localparam int clamp_b = 2;  // nCLAMP
  localparam int hsync_b = 1;  // nHSYNC
  localparam int csync_b = 0;  // nCSYNC

  // word position within one pixel slot
  typedef enum logic [1:0] {
    PH_SYNC = 2'd0,  // nVDSYNC low, sync nibble on VD_i[3:0]
    PH_R    = 2'd1,
    PH_G    = 2'd2,
    PH_B    = 2'd3
  } vbus_phase_e;

endpackage

/* src/deblur_cfg_pkg.sv */
package deblur_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // deblur configuration

  typedef enum logic [1:0] {
    DB_AUTO    = 2'd0,  // follow the per-frame estimate
    DB_MAN_ON  = 2'd1,  // always deblur (except 480i)
    DB_MAN_OFF = 2'd2   // never deblur
  } deblur_mode_e;

  // trend filter, a very simple mean over many frames
  localparam int trend_w = 9;
  // start in the middle, MSB set and the rest clear
  localparam logic [trend_w-1:0] trend_init = {1'b1, {(trend_w-1){1'b0}}};

  // sharp pairs needed per frame to vote for "no blur"
  localparam int est_cnt_max = 3;

endpackage

/* src/vbus_demux.sv */
`timescale 1ns/1ps

module vbus_demux
  import n64_vbus_pkg::*;
(
  input  logic               VCLK,
  input  logic               nRST,
  input  logic               nVDSYNC_i,    // low marks the sync word
  input  logic [color_w-1:0] VD_i,
  output vbus_phase_e        phase_o,      // phase of the word on VD_i now
  output logic [vdata_w-1:0] vdata_cur_o,  // pixel being assembled, live word merged in
  output logic [vdata_w-1:0] vdata_pre_o,  // last complete pixel
  output logic               new_pix_o,    // vdata_pre_o just got a new pixel
  output logic               vsync_fall_o, // nVSYNC falling, frame start
  output logic               csync_rise_o  // nCSYNC rising
);

  vbus_phase_e        phase_q;  // phase of the previous word
  logic [sync_w-1:0]  sync_q;   // stored sync nibble of the current pixel
  logic [color_w-1:0] r_q;
  logic [color_w-1:0] g_q;
  logic [color_w-1:0] b_q;
  logic               pix_done; // B word of a full pixel on the bus


  ////////////////////////////////////////////////////////////////////////////
  // phase tracking

  always_comb begin
    if (!nVDSYNC_i)
      phase_o = PH_SYNC;                      // resync on every sync word
    else if (phase_q == PH_B)
      phase_o = PH_B;                         // extra word, hold and swallow it
    else
      phase_o = vbus_phase_e'(phase_q + 2'd1);
  end

  // only a B that directly follows G completes a pixel
  assign pix_done = (phase_o == PH_B) && (phase_q == PH_G);

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      phase_q   <= PH_B;   // ignore words until the first sync
      sync_q    <= '1;     // idle bus level, all syncs inactive
      new_pix_o <= 1'b0;
    end else begin
      phase_q   <= phase_o;
      new_pix_o <= pix_done;
      if (phase_o == PH_SYNC)
        sync_q <= VD_i[sync_w-1:0];
    end
  end


  ////////////////////////////////////////////////////////////////////////////
  // pixel assembly

  // stored fields, with the word on the bus placed into its own field
  always_comb begin
    vdata_cur_o = {sync_q, r_q, g_q, b_q};
    case (phase_o)
      PH_SYNC: vdata_cur_o[sync_lsb +: sync_w] = VD_i[sync_w-1:0];
      PH_R:    vdata_cur_o[r_lsb +: color_w]   = VD_i;
      PH_G:    vdata_cur_o[g_lsb +: color_w]   = VD_i;
      default: vdata_cur_o[b_lsb +: color_w]   = VD_i;
    endcase
  end

  always_ff @(posedge VCLK) begin
    case (phase_o)
      PH_R:    r_q <= VD_i;
      PH_G:    g_q <= VD_i;
      PH_B:    b_q <= VD_i;
      default: ;            // sync nibble lives in sync_q
    endcase
    if (pix_done)
      vdata_pre_o <= vdata_cur_o;  // edge that samples B
  end


  ////////////////////////////////////////////////////////////////////////////
  // sync edges, incoming nibble against the stored one

  assign vsync_fall_o = !nVDSYNC_i &  sync_q[vsync_b] & !VD_i[vsync_b];
  assign csync_rise_o = !nVDSYNC_i & !sync_q[csync_b] &  VD_i[csync_b];

endmodule

/* src/deblur_estimator.sv */
`timescale 1ns/1ps

module deblur_estimator
  import n64_vbus_pkg::*, deblur_cfg_pkg::*;
#(
  parameter int TREND_W = trend_w
) (
  input  logic               VCLK,
  input  logic               nRST,
  input  vbus_phase_e        phase_i,
  input  logic [vdata_w-1:0] vdata_cur_i,
  input  logic [vdata_w-1:0] vdata_pre_i,
  input  logic               vsync_fall_i,
  input  logic               csync_rise_i,
  input  deblur_mode_e       mode_i,
  input  logic               n64_480i_i,
  input  logic               vmode_i,      // 1 = PAL
  output logic               blur_pix_o,   // pixel now on the bus is a blurry one
  output logic               ndo_deblur_o  // low = deblur active
);

  localparam int cmp_w = 3;  // only the top bits count for gradients
  localparam int cnt_w = $clog2(est_cnt_max + 1);
  localparam logic [cnt_w-1:0]   cnt_max   = cnt_w'(est_cnt_max);
  localparam logic [TREND_W-1:0] trend_rst = {1'b1, {(TREND_W-1){1'b0}}};

  logic               sync_word;
  logic               frame_start;
  logic               armed_q;      // skip the first frame after 480i or reset
  logic [TREND_W-1:0] trend_q;
  logic               nblur_q;      // 1 = console blur estimated off
  logic               nblur_d;
  logic [cnt_w-1:0]   cnt_q;        // sharp pairs seen this frame

  // gradient direction per color {falling, rising}, index 2 = R
  logic [2:0][1:0]    grad_q;
  logic [2:0]         rev_q;        // color reversed within the current pair
  logic               col_vld;
  logic [1:0]         col_idx;
  logic [cmp_w-1:0]   cmp_cur;
  logic [cmp_w-1:0]   cmp_pre;
  logic [1:0]         grad_new;

  assign sync_word   = (phase_i == PH_SYNC);
  assign frame_start = vsync_fall_i;  // strobe only exists on a sync word


  ////////////////////////////////////////////////////////////////////////////
  // pixel slot parity

  // toggles on each sync word; a line starts on a known parity per video mode
  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST)
      blur_pix_o <= 1'b0;
    else if (sync_word)
      blur_pix_o <= csync_rise_i ? ~vmode_i : ~blur_pix_o;
  end


  ////////////////////////////////////////////////////////////////////////////
  // gradient between the previous and the current pixel

  always_comb begin
    col_vld = 1'b1;
    col_idx = 2'd0;
    cmp_cur = '0;
    cmp_pre = '0;
    case (phase_i)
      PH_R: begin
        col_idx = 2'd2;
        cmp_cur = vdata_cur_i[r_lsb+color_w-1 -: cmp_w];
        cmp_pre = vdata_pre_i[r_lsb+color_w-1 -: cmp_w];
      end
      PH_G: begin
        col_idx = 2'd1;
        cmp_cur = vdata_cur_i[g_lsb+color_w-1 -: cmp_w];
        cmp_pre = vdata_pre_i[g_lsb+color_w-1 -: cmp_w];
      end
      PH_B: begin
        cmp_cur = vdata_cur_i[b_lsb+color_w-1 -: cmp_w];
        cmp_pre = vdata_pre_i[b_lsb+color_w-1 -: cmp_w];
      end
      default: col_vld = 1'b0;  // sync word carries no color
    endcase
  end

  assign grad_new = {cmp_pre > cmp_cur, cmp_pre < cmp_cur};


  ////////////////////////////////////////////////////////////////////////////
  // per-frame estimation and trend filter

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      armed_q <= 1'b0;
      trend_q <= trend_rst;
      nblur_q <= 1'b1;
      cnt_q   <= '0;
      grad_q  <= '0;
      rev_q   <= '0;
    end else if (n64_480i_i) begin
      armed_q <= 1'b0;                 // interlaced, estimation suspended
    end else begin
      if (frame_start) begin
        if (armed_q) begin
          if (cnt_q == cnt_max)        // enough sharp pairs, vote for no blur
            trend_q <= &trend_q ? trend_q : trend_q + 1'b1;
          else
            trend_q <= |trend_q ? trend_q - 1'b1 : trend_q;
          nblur_q <= trend_q[TREND_W-1];  // decision from the old trend
        end
        cnt_q   <= '0;
        armed_q <= 1'b1;
      end else if (sync_word && blur_pix_o) begin
        // a sharp/blurry pair just ended
        if (&rev_q && (cnt_q != cnt_max))
          cnt_q <= cnt_q + 1'b1;
        rev_q <= '0;
      end

      if (col_vld) begin
        if (!blur_pix_o)
          grad_q[col_idx] <= grad_new;                    // sharp slot
        else
          rev_q[col_idx]  <= &(grad_q[col_idx] ^ grad_new); // up then down or vice versa
      end
    end
  end

  // value nblur_q takes at this edge, so the output latch sees it in the same frame start
  assign nblur_d = (frame_start && armed_q && !n64_480i_i) ? trend_q[TREND_W-1] : nblur_q;


  ////////////////////////////////////////////////////////////////////////////
  // deblur decision, held for a whole frame

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      ndo_deblur_o <= 1'b0;
    end else if (frame_start) begin
      case (mode_i)
        DB_AUTO:    ndo_deblur_o <= n64_480i_i | nblur_d;
        DB_MAN_ON:  ndo_deblur_o <= n64_480i_i;
        DB_MAN_OFF: ndo_deblur_o <= 1'b1;
        default:    ndo_deblur_o <= 1'b1;  // unused code, leave pixels alone
      endcase
    end
  end

endmodule

/* src/deblur_apply.sv */
`timescale 1ns/1ps

module deblur_apply
  import n64_vbus_pkg::*;
(
  input  logic                 VCLK,
  input  logic                 nRST,
  input  logic                 new_pix_i,    // vdata_pre_i holds a fresh pixel
  input  logic [vdata_w-1:0]   vdata_pre_i,
  input  logic                 blur_pix_i,   // still refers to that pixel's slot
  input  logic                 ndo_deblur_i, // low = deblur active
  output logic                 pix_valid_o,
  output logic [3*color_w-1:0] pix_o,        // {R, G, B}
  output logic [sync_w-1:0]    sync_o
);

  localparam int rgb_w = 3*color_w;

  logic [rgb_w-1:0] rgb_in;       // RGB part of the fresh pixel
  logic [rgb_w-1:0] sharp_rgb_q;  // last pixel from a sharp slot
  logic             use_held;

  assign rgb_in   = vdata_pre_i[b_lsb +: rgb_w];
  assign use_held = !ndo_deblur_i && blur_pix_i;  // blurry slot while deblurring


  ////////////////////////////////////////////////////////////////////////////
  // sharp pixel hold

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST)
      sharp_rgb_q <= '0;
    else if (new_pix_i && !blur_pix_i)
      sharp_rgb_q <= rgb_in;
  end


  ////////////////////////////////////////////////////////////////////////////
  // output stage, one valid per pixel slot

  always_ff @(posedge VCLK or negedge nRST) begin
    if (!nRST) begin
      pix_valid_o <= 1'b0;
      pix_o       <= '0;
      sync_o      <= '1;  // all syncs inactive
    end else begin
      pix_valid_o <= new_pix_i;
      if (new_pix_i) begin
        pix_o  <= use_held ? sharp_rgb_q : rgb_in;  // repeat the sharp neighbour
        sync_o <= vdata_pre_i[sync_lsb +: sync_w];  // sync untouched
      end
    end
  end

endmodule

/* src/n64_vfront_top.sv */
`timescale 1ns/1ps

module n64_vfront_top
  import n64_vbus_pkg::*, deblur_cfg_pkg::*;
#(
  parameter int TREND_W = trend_w
) (
  input  logic                 VCLK,
  input  logic                 nRST,
  input  logic                 nVDSYNC_i,
  input  logic [color_w-1:0]   VD_i,
  input  deblur_mode_e         mode_i,
  input  logic                 n64_480i_i,
  input  logic                 vmode_i,
  output logic                 pix_valid_o,  // 2 clocks after the B word
  output logic [3*color_w-1:0] pix_o,
  output logic [sync_w-1:0]    sync_o,
  output logic                 ndo_deblur_o
);

  vbus_phase_e        phase;
  logic [vdata_w-1:0] vdata_cur;
  logic [vdata_w-1:0] vdata_pre;
  logic               new_pix;
  logic               vsync_fall;
  logic               csync_rise;
  logic               blur_pix;

  ////////////////////////////////////////////////////////////////////////////
  // bus demux

  vbus_demux u_demux (
    .VCLK         (VCLK),
    .nRST         (nRST),
    .nVDSYNC_i    (nVDSYNC_i),
    .VD_i         (VD_i),
    .phase_o      (phase),
    .vdata_cur_o  (vdata_cur),
    .vdata_pre_o  (vdata_pre),
    .new_pix_o    (new_pix),
    .vsync_fall_o (vsync_fall),
    .csync_rise_o (csync_rise)
  );

  ////////////////////////////////////////////////////////////////////////////
  // blur estimation and deblur

  deblur_estimator #(
    .TREND_W (TREND_W)
  ) u_estimator (
    .VCLK         (VCLK),
    .nRST         (nRST),
    .phase_i      (phase),
    .vdata_cur_i  (vdata_cur),
    .vdata_pre_i  (vdata_pre),
    .vsync_fall_i (vsync_fall),
    .csync_rise_i (csync_rise),
    .mode_i       (mode_i),
    .n64_480i_i   (n64_480i_i),
    .vmode_i      (vmode_i),
    .blur_pix_o   (blur_pix),
    .ndo_deblur_o (ndo_deblur_o)
  );

  deblur_apply u_apply (
    .VCLK         (VCLK),
    .nRST         (nRST),
    .new_pix_i    (new_pix),
    .vdata_pre_i  (vdata_pre),
    .blur_pix_i   (blur_pix),
    .ndo_deblur_i (ndo_deblur_o),
    .pix_valid_o  (pix_valid_o),
    .pix_o        (pix_o),
    .sync_o       (sync_o)
  );

endmodule

/* tb/tb_n64_vfront.sv */
`timescale 1ns/1ps

module tb_n64_vfront
  import n64_vbus_pkg::*, deblur_cfg_pkg::*;
();

  localparam int n_lines   = 4;
  localparam int n_pix     = 8;
  localparam int frame_cyc = n_lines * n_pix * 4;  // four bus words per pixel
  localparam int n_frames  = 17;                   // all tests together
  localparam int rgb_w     = 3*color_w;

  logic                 VCLK;
  logic                 nRST;
  logic                 nVDSYNC_i;
  logic [color_w-1:0]   VD_i;
  deblur_mode_e         mode_i;
  logic                 n64_480i_i;
  logic                 vmode_i;
  logic                 pix_valid_o;
  logic [rgb_w-1:0]     pix_o;
  logic [sync_w-1:0]    sync_o;
  logic                 ndo_deblur_o;

  int cyc;       // rising edges seen
  int err_cnt;

  // reference model state
  logic [trend_w-1:0] m_trend;
  int                 m_cnt;
  logic               m_armed;
  logic               m_nblur;
  logic               m_ndo;
  logic               m_parity;
  logic               m_prev_ok;
  logic [sync_w-1:0]  m_syncq;
  logic [1:0]         m_grad [3];  // {falling, rising} per color
  logic               m_rev  [3];
  logic [color_w-1:0] m_prev [3];
  logic [rgb_w-1:0]   m_held;
  logic               zz;          // zig-zag level

  // expected output stream
  logic [rgb_w-1:0]  exp_rgb_q  [$];
  logic [sync_w-1:0] exp_sync_q [$];
  int                exp_cyc_q  [$];

  n64_vfront_top #(.TREND_W(trend_w)) uut (.*);

  initial begin
    VCLK = 1'b0;
    forever #10 VCLK = ~VCLK;
  end

  always @(posedge VCLK) cyc <= cyc + 1;

  task automatic fail_run(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  // watchdog over the whole test length plus some slack
  initial begin
    #((n_frames * frame_cyc + 500) * 20);
    $display("timeout, the tests did not finish in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // output monitor sampling on the falling edge

  always @(negedge VCLK) begin : monitor
    logic [rgb_w-1:0]  e_rgb;
    logic [sync_w-1:0] e_sync;
    int                e_cyc;
    if (nRST && pix_valid_o) begin
      assert (exp_rgb_q.size() > 0)
        else fail_run("pix_valid_o went high with no pixel expected");
      e_rgb  = exp_rgb_q.pop_front();
      e_sync = exp_sync_q.pop_front();
      e_cyc  = exp_cyc_q.pop_front();
      assert (pix_o === e_rgb)
        else fail_run($sformatf("FAIL pix_o got %h expected %h", pix_o, e_rgb));
      assert (sync_o === e_sync)
        else fail_run($sformatf("FAIL sync_o got %h expected %h", sync_o, e_sync));
      assert (cyc == e_cyc)
        else fail_run($sformatf("FAIL pix_valid_o cycle got %h expected %h", cyc, e_cyc));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus driver with the reference model

  // one pixel slot is the sync word followed by R, G and B
  task automatic send_pixel(input logic [3:0] nib, input logic [color_w-1:0] r,
                            input logic [color_w-1:0] g, input logic [color_w-1:0] b);
    logic               fall;
    logic               rise;
    logic               nb;
    logic [color_w-1:0] cur [3];
    logic [2:0]         pt;
    logic [2:0]         ct;
    logic [1:0]         dir;
    logic [rgb_w-1:0]   rgb;
    logic [rgb_w-1:0]   e_rgb;
    cur[0] = r;
    cur[1] = g;
    cur[2] = b;
    fall = m_syncq[vsync_b] & !nib[vsync_b];
    rise = !m_syncq[csync_b] & nib[csync_b];
    // edge that samples the sync word
    nb = (fall && m_armed && !n64_480i_i) ? m_trend[trend_w-1] : m_nblur;
    if (n64_480i_i) begin
      m_armed = 1'b0;
    end else if (fall) begin
      if (m_armed) begin
        if (m_cnt == est_cnt_max) begin
          if (m_trend != '1) m_trend = m_trend + 1'b1;
        end else if (m_trend != '0) begin
          m_trend = m_trend - 1'b1;
        end
        m_nblur = nb;
      end
      m_cnt   = 0;
      m_armed = 1'b1;
    end else if (m_parity) begin
      if (m_rev[0] && m_rev[1] && m_rev[2] && m_cnt != est_cnt_max) m_cnt++;
      for (int c = 0; c < 3; c++) m_rev[c] = 1'b0;
    end
    if (fall) begin
      case (mode_i)
        DB_AUTO:   m_ndo = n64_480i_i | nb;
        DB_MAN_ON: m_ndo = n64_480i_i;
        default:   m_ndo = 1'b1;
      endcase
    end
    m_parity = rise ? ~vmode_i : ~m_parity;
    m_syncq  = nib;
    // gradient of each color on its top 3 bits
    if (!n64_480i_i && m_prev_ok) begin
      for (int c = 0; c < 3; c++) begin
        pt  = m_prev[c][color_w-1 -: 3];
        ct  = cur[c][color_w-1 -: 3];
        dir = {pt > ct, pt < ct};
        if (!m_parity) m_grad[c] = dir;
        else           m_rev[c]  = ((m_grad[c] ^ dir) == 2'b11);
      end
    end
    rgb   = {r, g, b};
    e_rgb = (!m_ndo && m_parity) ? m_held : rgb;
    if (!m_parity) m_held = rgb;

    @(posedge VCLK); #2;
    nVDSYNC_i = 1'b0;
    VD_i      = {3'b000, nib};
    @(posedge VCLK); #2;
    nVDSYNC_i = 1'b1;
    VD_i      = r;
    assert (ndo_deblur_o === m_ndo)
      else fail_run($sformatf("FAIL ndo_deblur_o got %h expected %h", ndo_deblur_o, m_ndo));
    @(posedge VCLK); #2;
    VD_i = g;
    @(posedge VCLK); #2;
    VD_i = b;
    exp_rgb_q.push_back(e_rgb);
    exp_sync_q.push_back(nib);
    exp_cyc_q.push_back(cyc + 2);  // fixed latency from the B word to valid
    for (int c = 0; c < 3; c++) m_prev[c] = cur[c];
    m_prev_ok = 1'b1;
  endtask

  // kind 0 is random, 1 flat and 2 zig-zag
  task automatic send_frame(input int kind);
    logic [3:0]         nib;
    logic [color_w-1:0] col [3];
    for (int l = 0; l < n_lines; l++) begin
      for (int p = 0; p < n_pix; p++) begin
        nib = 4'hF;
        if (p == 0) nib = (l == 0) ? 4'h4 : 4'hC;  // hsync and csync low, vsync too on line 0
        zz = ~zz;
        for (int c = 0; c < 3; c++) begin
          case (kind)
            0:       col[c] = color_w'($urandom % 128);
            1:       col[c] = 7'h2A;
            default: col[c] = zz ? 7'h7F : 7'h00;
          endcase
        end
        send_pixel(nib, col[0], col[1], col[2]);
      end
    end
  endtask

  task automatic drain();
    repeat (4) @(posedge VCLK);
    #2;
    assert (exp_rgb_q.size() == 0)
      else fail_run("pixels were sent but never came out");
  endtask

  task automatic apply_reset();
    nRST      = 1'b0;
    nVDSYNC_i = 1'b1;
    VD_i      = '0;
    repeat (4) @(posedge VCLK);
    #2 nRST = 1'b1;
    m_trend   = trend_init;
    m_cnt     = 0;
    m_armed   = 1'b0;
    m_nblur   = 1'b1;
    m_ndo     = 1'b0;
    m_parity  = 1'b0;
    m_prev_ok = 1'b0;
    m_syncq   = '1;
    m_held    = '0;
    for (int c = 0; c < 3; c++) begin
      m_grad[c] = 2'b00;
      m_rev[c]  = 1'b0;
    end
    exp_rgb_q.delete();
    exp_sync_q.delete();
    exp_cyc_q.delete();
    assert (pix_valid_o === 1'b0 && pix_o === '0 && sync_o === 4'hF && ndo_deblur_o === 1'b0)
      else fail_run("outputs are not at their reset values");
    send_pixel(4'hF, 7'h11, 7'h22, 7'h33);  // first pixel only fills the pipe
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic demux_stream();
    mode_i = DB_MAN_OFF;
    apply_reset();
    repeat (2) send_frame(0);
    drain();
  endtask

  task automatic manual_modes();
    mode_i = DB_MAN_ON;
    send_frame(0);
    assert (ndo_deblur_o === 1'b0)
      else fail_run($sformatf("FAIL ndo_deblur_o got %h expected %h", ndo_deblur_o, 1'b0));
    mode_i = DB_MAN_OFF;
    send_frame(0);
    assert (ndo_deblur_o === 1'b1)
      else fail_run($sformatf("FAIL ndo_deblur_o got %h expected %h", ndo_deblur_o, 1'b1));
    mode_i     = DB_MAN_ON;
    n64_480i_i = 1'b1;
    send_frame(0);
    assert (ndo_deblur_o === 1'b1)
      else fail_run($sformatf("FAIL ndo_deblur_o got %h expected %h", ndo_deblur_o, 1'b1));
    n64_480i_i = 1'b0;
    drain();
  endtask

  task automatic deblur_replace();
    mode_i = DB_MAN_ON;
    apply_reset();
    send_frame(0);
    vmode_i = 1'b1;  // PAL parity on each line
    send_frame(0);
    vmode_i = 1'b0;
    drain();
  endtask

  task automatic flat_estimate();
    logic exp_ndo [4];
    exp_ndo = '{1'b1, 1'b1, 1'b0, 1'b0};
    mode_i  = DB_AUTO;
    apply_reset();
    for (int f = 0; f < 4; f++) begin
      send_frame(1);
      assert (ndo_deblur_o === exp_ndo[f])
        else fail_run($sformatf("FAIL ndo_deblur_o got %h expected %h",
                                ndo_deblur_o, exp_ndo[f]));
    end
    drain();
  endtask

  task automatic zigzag_estimate();
    logic [trend_w-1:0] trend_keep;
    mode_i = DB_AUTO;
    apply_reset();
    repeat (4) send_frame(2);
    assert (ndo_deblur_o === 1'b1 && uut.u_estimator.trend_q > trend_init)
      else fail_run("zig-zag frames did not raise the trend or deblur got enabled");
    n64_480i_i = 1'b1;
    send_frame(2);
    n64_480i_i = 1'b0;
    trend_keep = m_trend;
    send_frame(2);  // disarmed frame start
    assert (uut.u_estimator.trend_q === trend_keep)
      else fail_run($sformatf("FAIL trend_q got %h expected %h",
                              uut.u_estimator.trend_q, trend_keep));
    drain();
  endtask

  initial begin
    nRST       = 1'b0;
    nVDSYNC_i  = 1'b1;
    VD_i       = '0;
    mode_i     = DB_MAN_OFF;
    n64_480i_i = 1'b0;
    vmode_i    = 1'b0;
    cyc        = 0;
    err_cnt    = 0;
    zz         = 1'b0;
    void'($urandom(32'h36ae));
    demux_stream();
    manual_modes();
    deblur_replace();
    flat_estimate();
    zigzag_estimate();
    if (err_cnt == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* n64_vfront.f */
src/n64_vbus_pkg.sv
src/deblur_cfg_pkg.sv
src/vbus_demux.sv
src/deblur_estimator.sv
src/deblur_apply.sv
src/n64_vfront_top.sv
tb/tb_n64_vfront.sv

/* Bender.yml */
package:
  name: n64_vfront

sources:
  - src/n64_vbus_pkg.sv
  - src/deblur_cfg_pkg.sv
  - src/vbus_demux.sv
  - src/deblur_estimator.sv
  - src/deblur_apply.sv
  - src/n64_vfront_top.sv
  - target: simulation
    files:
      - tb/tb_n64_vfront.sv
